/* src/prefetch_settings.svh */
// --------------------------------------------------
// Build-time sizes of the instruction prefetch unit
// Line count of the line cache, address and line width
// --------------------------------------------------

`ifndef PREFETCH_SETTINGS_SVH
`define PREFETCH_SETTINGS_SVH

// Number of cached lines, must be a power of two
`define PF_LINES  4

// Fetch address width in bits
`define PF_ADDR_W 32

// One cache line, 8 halfwords
`define PF_LINE_W 128

`endif

/* src/fetch_addr_pkg.sv */
// --------------------------------------------------
// Fetch address, cache line and instruction types
// --------------------------------------------------

`include "prefetch_settings.svh"

package fetch_addr_pkg;

   // Line number plus byte offset, offset[3:1] is the halfword index
   typedef struct packed {
      logic [`PF_ADDR_W-5:0] line;
      logic [3:0]            offset;
   } fetch_addr_fields_t;

   // Same address, flat or split
   typedef union packed {
      logic [`PF_ADDR_W-1:0] word;
      fetch_addr_fields_t    fields;
   } fetch_addr_u;

   typedef logic [`PF_LINE_W/16-1:0][15:0] line_t;  // Halfword 0 at the lowest address
   typedef logic [31:0]                    instr_t;
   typedef logic [$clog2(`PF_LINES)-1:0]   way_idx_t;  // Cache way pointer

endpackage

/* src/fetch_bus_pkg.sv */
// --------------------------------------------------
// Memory port structs of the prefetch unit
// Request, response and requester identifiers
// --------------------------------------------------

`include "prefetch_settings.svh"

package fetch_bus_pkg;

   // Request toward memory, address always line aligned
   typedef struct packed {
      logic                  req;
      logic [`PF_ADDR_W-1:0] addr;
   } iport_req_t;

   // Grant and read data from memory
   typedef struct packed {
      logic                  gnt;
      logic                  rvalid;
      logic [`PF_LINE_W-1:0] rdata;
   } iport_rsp_t;

   // Owner of an access on the shared port
   typedef enum logic {DEMAND = 1'b0, PREFETCH = 1'b1} requester_e;

endpackage

/* src/line_cache.sv */
// --------------------------------------------------
// Fully associative line cache
// Two combinational lookup ports, one fill port, flush
// Round-robin replacement
// --------------------------------------------------

`include "prefetch_settings.svh"

module line_cache (
   input  logic                        clk,
   input  logic                        rst_n,
   input  fetch_addr_pkg::fetch_addr_u lookup_a_i,   // Aligner line
   output logic                        hit_a_o,
   output fetch_addr_pkg::line_t       line_a_o,
   input  fetch_addr_pkg::fetch_addr_u lookup_b_i,   // Prefetch probe
   output logic                        hit_b_o,
   input  logic                        fill_valid_i,
   input  fetch_addr_pkg::fetch_addr_u fill_addr_i,
   input  fetch_addr_pkg::line_t       fill_data_i,
   input  logic                        flush_i
);
   localparam int LINES = `PF_LINES;

   logic [LINES-1:0]         valid_q;
   logic [`PF_ADDR_W-5:0]    tag_q  [LINES];
   fetch_addr_pkg::line_t    data_q [LINES];
   fetch_addr_pkg::way_idx_t rr_q;       // Next victim
   fetch_addr_pkg::way_idx_t fill_way;
   logic                     fill_hit;   // Fill line already cached

   // Tag compare on all ways
   always_comb begin
      hit_a_o  = 1'b0;
      hit_b_o  = 1'b0;
      line_a_o = '0;
      fill_hit = 1'b0;
      fill_way = rr_q;
      for (int i = 0; i < LINES; i++) begin
         if (valid_q[i] && tag_q[i] == lookup_a_i.fields.line) begin
            hit_a_o  = 1'b1;
            line_a_o = data_q[i];
         end
         if (valid_q[i] && tag_q[i] == lookup_b_i.fields.line)
            hit_b_o = 1'b1;
         if (valid_q[i] && tag_q[i] == fill_addr_i.fields.line) begin
            fill_hit = 1'b1;                                  // Overwrite in place
            fill_way = fetch_addr_pkg::way_idx_t'(i);
         end
      end
   end

   // --------------------------------------------------
   // Valid bits and victim pointer
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= '0;
         rr_q    <= '0;
      end else if (flush_i) begin
         valid_q <= '0;                                       // Fence drops everything
      end else if (fill_valid_i) begin
         valid_q[fill_way] <= 1'b1;
         if (!fill_hit) rr_q <= rr_q + 1'b1;                  // Wraps, power of two
      end
   end

   // Tag and data store
   always_ff @(posedge clk) begin
      if (fill_valid_i && !flush_i) begin
         tag_q[fill_way]  <= fill_addr_i.fields.line;
         data_q[fill_way] <= fill_data_i;
      end
   end

endmodule

/* src/iport_arbiter.sv */
// --------------------------------------------------
// Memory port arbiter, demand over prefetch
// Single outstanding access, fence drop of late data
// --------------------------------------------------

module iport_arbiter (
   input  logic                        clk,
   input  logic                        rst_n,
   input  fetch_bus_pkg::iport_req_t   dem_req_i,
   input  fetch_bus_pkg::iport_req_t   pf_req_i,
   output logic                        dem_gnt_o,
   output logic                        pf_gnt_o,
   output logic                        fill_valid_o,
   output fetch_bus_pkg::requester_e   fill_src_o,
   output fetch_addr_pkg::fetch_addr_u fill_addr_o,
   output fetch_addr_pkg::line_t       fill_data_o,
   input  logic                        fence_i,
   output fetch_bus_pkg::iport_req_t   iport_req_o,
   input  fetch_bus_pkg::iport_rsp_t   iport_rsp_i,
   output logic                        busy_o
);
   logic                        hold_q;    // Request on the port, not yet granted
   logic                        out_q;     // Granted, waiting for rvalid
   logic                        drop_q;    // Answer belongs to a fenced access
   fetch_bus_pkg::requester_e   src_q, sel_src;
   fetch_addr_pkg::fetch_addr_u addr_q, sel_addr;
   logic                        fwd_req, granted;

   // Keep the locked choice, otherwise demand first
   always_comb begin
      sel_src       = fetch_bus_pkg::DEMAND;
      sel_addr.word = dem_req_i.addr;
      if (hold_q) begin
         sel_src  = src_q;
         sel_addr = addr_q;
      end else if (!dem_req_i.req) begin
         sel_src       = fetch_bus_pkg::PREFETCH;
         sel_addr.word = pf_req_i.addr;
      end
   end

   assign fwd_req     = hold_q || (!out_q && (dem_req_i.req || pf_req_i.req));
   assign granted     = fwd_req && iport_rsp_i.gnt;
   assign iport_req_o = '{req: fwd_req, addr: sel_addr.word};
   assign dem_gnt_o   = granted && sel_src == fetch_bus_pkg::DEMAND;
   assign pf_gnt_o    = granted && sel_src == fetch_bus_pkg::PREFETCH;
   assign busy_o      = fwd_req || out_q;

   // Fill pulse to cache and aligner
   assign fill_valid_o = iport_rsp_i.rvalid && out_q && !drop_q && !fence_i;
   assign fill_src_o   = src_q;
   assign fill_addr_o  = addr_q;
   assign fill_data_o  = iport_rsp_i.rdata;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hold_q <= 1'b0;
         out_q  <= 1'b0;
         drop_q <= 1'b0;
      end else begin
         hold_q <= fwd_req && !iport_rsp_i.gnt;
         if (granted) out_q <= 1'b1;
         else if (iport_rsp_i.rvalid) out_q <= 1'b0;
         if (iport_rsp_i.rvalid) drop_q <= 1'b0;
         else if (fence_i && (out_q || granted)) drop_q <= 1'b1;  // Data may be stale
      end
   end

   // Owner and address, frozen while outstanding
   always_ff @(posedge clk) begin
      if (fwd_req) begin
         src_q  <= sel_src;
         addr_q <= sel_addr;
      end
   end

endmodule

/* src/line_prefetcher.sv */
// --------------------------------------------------
// Next-line prefetcher
// Probes the line after the current one, fetches on miss
// --------------------------------------------------

module line_prefetcher (
   input  logic                        clk,
   input  logic                        rst_n,
   input  fetch_addr_pkg::fetch_addr_u cur_addr_i,
   input  logic                        next_hit_i,
   output fetch_addr_pkg::fetch_addr_u probe_o,
   output fetch_bus_pkg::iport_req_t   pf_req_o,
   input  logic                        pf_gnt_i,
   input  logic                        fill_valid_i,
   input  fetch_bus_pkg::requester_e   fill_src_i,
   input  logic                        redirect_i
);
   fetch_addr_pkg::fetch_addr_u next_addr, req_addr_q;
   logic                        req_q, wait_q;

   always_comb begin
      next_addr.fields.line   = cur_addr_i.fields.line + 1'b1;
      next_addr.fields.offset = 4'h0;                         // Line aligned
   end

   assign probe_o  = next_addr;
   assign pf_req_o = '{req: req_q, addr: req_addr_q.word};

   // Idle, request, wait for own fill
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         req_q  <= 1'b0;
         wait_q <= 1'b0;
      end else if (redirect_i) begin
         req_q  <= 1'b0;                                      // Drop ungranted request
         wait_q <= 1'b0;
      end else if (req_q) begin
         if (pf_gnt_i) begin
            req_q  <= 1'b0;
            wait_q <= 1'b1;
         end
      end else if (wait_q) begin
         if (fill_valid_i && fill_src_i == fetch_bus_pkg::PREFETCH) wait_q <= 1'b0;
      end else if (!next_hit_i) begin
         req_q <= 1'b1;
      end
   end

   // Address tracks the probe until the request is raised
   always_ff @(posedge clk) begin
      if (!req_q) req_addr_q <= next_addr;
   end

endmodule

/* src/instr_aligner.sv */
// --------------------------------------------------
// Instruction aligner
// Fetch address, 16/32-bit extraction, cross-line join
// Demand line requests and output register
// --------------------------------------------------

`include "prefetch_settings.svh"

module instr_aligner (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        branch_i,
   input  logic                        ready_i,
   input  fetch_addr_pkg::fetch_addr_u addr_i,
   output fetch_addr_pkg::fetch_addr_u cur_addr_o,
   output fetch_addr_pkg::fetch_addr_u lookup_o,
   input  logic                        hit_i,
   input  fetch_addr_pkg::line_t       line_i,
   output fetch_bus_pkg::iport_req_t   dem_req_o,
   input  logic                        dem_gnt_i,
   input  logic                        fill_valid_i,
   input  fetch_bus_pkg::requester_e   fill_src_i,
   input  fetch_addr_pkg::line_t       fill_data_i,
   output logic                        valid_o,
   output fetch_addr_pkg::instr_t      rdata_o,
   output fetch_addr_pkg::fetch_addr_u addr_o
);
   fetch_addr_pkg::fetch_addr_u pc_q, look, addr_q;
   fetch_addr_pkg::line_t       cur_line;
   fetch_addr_pkg::instr_t      nxt_instr, rdata_q;
   logic [`PF_ADDR_W-5:0]       req_line_q, pend_line_q;
   logic [`PF_ADDR_W-1:0]       step;
   logic [15:0]                 hw_lo, hw_hi, xl_half_q;
   logic [2:0]                  hw_idx, hw_nxt;
   logic                        run_q, xl_q, valid_q, req_q, pend_q;
   logic                        fill_ok, line_ok, advance, is32, to_xl;

   // Cross-line state looks at the following line
   always_comb begin
      look.fields.line   = xl_q ? pc_q.fields.line + 1'b1 : pc_q.fields.line;
      look.fields.offset = xl_q ? 4'h0 : pc_q.fields.offset;
   end

   // Own demand fill can be used in its arrival cycle
   assign fill_ok = fill_valid_i && fill_src_i == fetch_bus_pkg::DEMAND && pend_q &&
                    pend_line_q == look.fields.line;
   assign line_ok = hit_i || fill_ok;
   assign advance = run_q && !branch_i && (!valid_q || ready_i) && line_ok;

   // --------------------------------------------------
   // Halfword extraction
   always_comb begin
      cur_line = hit_i ? line_i : fill_data_i;
      hw_idx   = pc_q.fields.offset[3:1];
      hw_nxt   = hw_idx + 3'd1;
      hw_lo    = cur_line[hw_idx];
      hw_hi    = cur_line[hw_nxt];
      is32     = hw_lo[1:0] == 2'b11;                         // Not compressed
      to_xl    = !xl_q && is32 && hw_idx == 3'd7;             // Upper half in next line
      step     = (xl_q || is32) ? `PF_ADDR_W'(4) : `PF_ADDR_W'(2);
      if (xl_q)      nxt_instr = {cur_line[0], xl_half_q};
      else if (is32) nxt_instr = {hw_hi, hw_lo};
      else           nxt_instr = {16'h0, hw_lo};
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc_q    <= '0;
         run_q   <= 1'b0;                                     // Idle until first branch
         xl_q    <= 1'b0;
         valid_q <= 1'b0;
      end else if (branch_i) begin
         pc_q    <= addr_i;
         run_q   <= 1'b1;
         xl_q    <= 1'b0;
         valid_q <= 1'b0;                                     // Kill output
      end else if (advance) begin
         xl_q    <= to_xl;
         valid_q <= !to_xl;
         if (!to_xl) pc_q.word <= pc_q.word + step;
      end else if (ready_i) begin
         valid_q <= 1'b0;                                     // Taken, nothing new
      end
   end

   // Demand request, held until grant, one in flight
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         req_q  <= 1'b0;
         pend_q <= 1'b0;
      end else begin
         if (req_q) begin
            if (dem_gnt_i) begin
               req_q  <= 1'b0;
               pend_q <= 1'b1;
            end
         end else if (run_q && !branch_i && !line_ok && !pend_q) begin
            req_q <= 1'b1;
         end
         if (fill_valid_i && fill_src_i == fetch_bus_pkg::DEMAND) pend_q <= 1'b0;
         if (branch_i) pend_q <= 1'b0;                        // Old answer is not ours
      end
   end

   always_ff @(posedge clk) begin
      if (advance && to_xl) xl_half_q <= hw_lo;
      if (advance && !to_xl) begin
         rdata_q <= nxt_instr;
         addr_q  <= pc_q;
      end
      if (!req_q) req_line_q <= look.fields.line;
      if (req_q && dem_gnt_i) pend_line_q <= req_line_q;
   end

   assign cur_addr_o = pc_q;
   assign lookup_o   = look;
   assign dem_req_o  = '{req: req_q, addr: {req_line_q, 4'h0}};
   assign valid_o    = valid_q;
   assign rdata_o    = rdata_q;
   assign addr_o     = addr_q;

endmodule

/* src/instr_prefetch_top.sv */
// --------------------------------------------------
// Instruction prefetch unit top level
// Cache, port arbiter, prefetcher and aligner
// --------------------------------------------------

module instr_prefetch_top (
   input  logic                        clk,
   input  logic                        rst_n,
   output fetch_bus_pkg::iport_req_t   iport_req_o,
   input  fetch_bus_pkg::iport_rsp_t   iport_rsp_i,
   input  logic                        branch_i,
   input  logic                        fence_i,
   input  logic                        ready_i,
   input  fetch_addr_pkg::fetch_addr_u addr_i,
   output logic                        valid_o,
   output logic                        busy_o,
   output fetch_addr_pkg::instr_t      rdata_o,
   output fetch_addr_pkg::fetch_addr_u addr_o
);
   fetch_addr_pkg::fetch_addr_u cur_addr, lookup, probe, fill_addr;
   fetch_addr_pkg::line_t       line_a, fill_data;
   fetch_bus_pkg::iport_req_t   dem_req, pf_req;
   fetch_bus_pkg::requester_e   fill_src;
   logic                        hit_a, hit_b, dem_gnt, pf_gnt, fill_valid;

   line_cache u_cache (
      .clk, .rst_n,
      .lookup_a_i (lookup),   .hit_a_o (hit_a), .line_a_o (line_a),
      .lookup_b_i (probe),    .hit_b_o (hit_b),
      .fill_valid_i (fill_valid), .fill_addr_i (fill_addr), .fill_data_i (fill_data),
      .flush_i (fence_i)
   );

   iport_arbiter u_arb (
      .clk, .rst_n,
      .dem_req_i (dem_req), .pf_req_i (pf_req), .dem_gnt_o (dem_gnt), .pf_gnt_o (pf_gnt),
      .fill_valid_o (fill_valid), .fill_src_o (fill_src),
      .fill_addr_o (fill_addr), .fill_data_o (fill_data),
      .fence_i, .iport_req_o, .iport_rsp_i, .busy_o
   );

   line_prefetcher u_pf (
      .clk, .rst_n,
      .cur_addr_i (cur_addr), .next_hit_i (hit_b), .probe_o (probe),
      .pf_req_o (pf_req), .pf_gnt_i (pf_gnt),
      .fill_valid_i (fill_valid), .fill_src_i (fill_src), .redirect_i (branch_i)
   );

   instr_aligner u_align (
      .clk, .rst_n, .branch_i, .ready_i, .addr_i,
      .cur_addr_o (cur_addr), .lookup_o (lookup), .hit_i (hit_a), .line_i (line_a),
      .dem_req_o (dem_req), .dem_gnt_i (dem_gnt),
      .fill_valid_i (fill_valid), .fill_src_i (fill_src), .fill_data_i (fill_data),
      .valid_o, .rdata_o, .addr_o
   );

endmodule

/* tests/prefetch_properties.sv */
// --------------------------------------------------
// Concurrent checks on the memory port
// and on the core-side output hold rule
// --------------------------------------------------

module prefetch_properties (
   input logic                        clk,
   input logic                        rst_n,
   input fetch_bus_pkg::iport_req_t   iport_req_o,
   input fetch_bus_pkg::iport_rsp_t   iport_rsp_i,
   input logic                        branch_i,
   input logic                        ready_i,
   input logic                        valid_o,
   input fetch_addr_pkg::instr_t      rdata_o,
   input fetch_addr_pkg::fetch_addr_u addr_o
);
   timeunit 1ns;
   timeprecision 1ps;

   int   fail_cnt = 0;   // Read by the testbench top
   logic open_q;         // Granted, rvalid still due

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) open_q <= 1'b0;
      else if (iport_req_o.req && iport_rsp_i.gnt) open_q <= 1'b1;
      else if (iport_rsp_i.rvalid) open_q <= 1'b0;
   end

   // Request stays up with the same address until granted
   req_held: assert property (@(posedge clk) disable iff (!rst_n)
      iport_req_o.req && !iport_rsp_i.gnt |=> iport_req_o.req && $stable(iport_req_o.addr))
      else begin $error("request dropped or moved before grant"); fail_cnt++; end

   one_open: assert property (@(posedge clk) disable iff (!rst_n)
      open_q |-> !iport_req_o.req)   // No second access in flight
      else begin $error("new request while an access is outstanding"); fail_cnt++; end

   rvalid_granted: assert property (@(posedge clk) disable iff (!rst_n)
      iport_rsp_i.rvalid |-> open_q)
      else begin $error("rvalid without a granted access"); fail_cnt++; end

   // Held output keeps data and address
   out_hold: assert property (@(posedge clk) disable iff (!rst_n)
      valid_o && !ready_i && !branch_i |=> valid_o && $stable(rdata_o) && $stable(addr_o))
      else begin $error("output changed while held by ready low"); fail_cnt++; end

   branch_kill: assert property (@(posedge clk) disable iff (!rst_n)
      branch_i |=> !valid_o)
      else begin $error("valid high in the cycle after a branch"); fail_cnt++; end

endmodule

/* tests/prefetch_tb.sv */
// --------------------------------------------------
// Testbench of the instruction prefetch unit
// Clock, reset, memory model, reference model
// Compare tasks, test sequence and watchdog
// --------------------------------------------------

module prefetch_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int N_STREAM    = 200;   // Transfers in a stream test
   localparam int N_BRANCHES  = 20;
   localparam int N_PER_BR    = 20;
   localparam int TOTAL_XFERS = 4 * N_STREAM + N_BRANCHES * N_PER_BR;
   localparam int CYCLE_NS    = 40;

   logic clk, rst_n, branch, fence, ready, valid, busy;
   fetch_addr_pkg::fetch_addr_u addr_in, addr_out;
   fetch_addr_pkg::instr_t      rdata;
   fetch_bus_pkg::iport_req_t   iport_req;
   fetch_bus_pkg::iport_rsp_t   iport_rsp;

   int          errors = 0, port_errors = 0, xfers = 0;
   logic [7:0]  gen = 8'd0;   // Memory contents generation
   logic [31:0] ref_pc;       // Reference model address

   // Memory model state sampled mid-cycle
   logic        req_seen, gnt_seen, rvalid_seen;
   logic [31:0] req_addr_seen, mem_addr;
   logic [7:0]  gen_seen, mem_gen;
   int          wait_cnt = 0;

   instr_prefetch_top uut (
      .clk, .rst_n, .iport_req_o (iport_req), .iport_rsp_i (iport_rsp),
      .branch_i (branch), .fence_i (fence), .ready_i (ready), .addr_i (addr_in),
      .valid_o (valid), .busy_o (busy), .rdata_o (rdata), .addr_o (addr_out)
   );

   bind instr_prefetch_top prefetch_properties u_props (
      .clk, .rst_n, .iport_req_o, .iport_rsp_i, .branch_i, .ready_i, .valid_o, .rdata_o, .addr_o
   );

   initial begin
      clk = 1'b0;
      forever #(CYCLE_NS / 2) clk = ~clk;
   end

   // Halfword at a byte address
   // Odd generations favour 32-bit starts at offset 14
   function automatic logic [15:0] mem_half(input logic [31:0] a, input logic [7:0] g);
      logic [15:0] h;
      h = 16'((a[31:1] * 32'h9e37_79b1) >> 7) ^ {g, ~g};
      if (g[0] && a[3:1] == 3'd7 && h[4]) h[1:0] = 2'b11;
      return h;
   endfunction

   function automatic fetch_addr_pkg::line_t make_line(input logic [31:0] a, input logic [7:0] g);
      fetch_addr_pkg::line_t l;
      for (int i = 0; i < 8; i++) l[i] = mem_half({a[31:4], 4'h0} + 32'(2 * i), g);
      return l;
   endfunction

   // Expected instruction at the model address
   function automatic fetch_addr_pkg::instr_t ref_instr(input logic [31:0] a);
      logic [15:0] lo;
      lo = mem_half(a, gen);
      if (lo[1:0] == 2'b11) return {mem_half(a + 32'd2, gen), lo};
      return {16'h0, lo};
   endfunction

   task automatic check_instr(input fetch_addr_pkg::instr_t got,
                              input fetch_addr_pkg::instr_t exp);
      if (got !== exp) begin
         errors++;
         $display("ERROR %0t: instruction %h, expected %h", $time, got, exp);
      end
   endtask

   task automatic check_addr(input fetch_addr_pkg::fetch_addr_u got,
                             input fetch_addr_pkg::fetch_addr_u exp);
      if (got.word !== exp.word) begin
         errors++;
         $display("ERROR %0t: address %h, expected %h", $time, got.word, exp.word);
      end
   endtask

   task automatic check_busy(input logic got, input logic exp);
      if (got !== exp) begin
         port_errors++;
         $display("ERROR %0t: busy %b, expected %b", $time, got, exp);
      end
   endtask

   // --------------------------------------------------
   // Memory port model
   always @(negedge clk) begin
      req_seen      = iport_req.req;
      req_addr_seen = iport_req.addr;
      gnt_seen      = iport_rsp.gnt;
      rvalid_seen   = iport_rsp.rvalid;
      gen_seen      = gen;
      // Busy means a request on the port or an access still owed an rvalid
      if (rst_n) check_busy(busy, iport_req.req || wait_cnt != 0 || iport_rsp.rvalid);
   end

   always @(posedge clk) begin
      iport_rsp.rvalid <= 1'b0;
      if (req_seen && gnt_seen) begin
         if (wait_cnt != 0 || rvalid_seen) begin
            port_errors++;
            $display("ERROR %0t: grant while an access is outstanding", $time);
         end
         mem_addr = req_addr_seen;
         mem_gen  = gen_seen;                  // Contents fixed at grant
         wait_cnt = $urandom_range(1, 4);
      end
      if (wait_cnt == 1) begin
         iport_rsp.rvalid <= 1'b1;
         iport_rsp.rdata  <= make_line(mem_addr, mem_gen);
      end
      if (wait_cnt != 0) wait_cnt--;
      iport_rsp.gnt <= 1'($urandom_range(0, 1));
   end

   // Branch with optional generation bump and fence
   task automatic do_branch(input logic [31:0] target, input logic with_fence);
      @(posedge clk);
      if (with_fence) gen <= gen + 8'd1;
      @(posedge clk);
      branch       <= 1'b1;
      fence        <= with_fence;
      addr_in.word <= target;
      @(posedge clk);
      branch <= 1'b0;
      fence  <= 1'b0;
      ref_pc = target;
   endtask

   // Count n transfers and compare each with the model
   task automatic run_stream(input int n, input bit rand_ready);
      int                          got;
      fetch_addr_pkg::instr_t      exp;
      fetch_addr_pkg::fetch_addr_u exp_addr;
      got = 0;
      while (got < n) begin
         @(posedge clk);
         ready <= rand_ready ? 1'($urandom_range(0, 1)) : 1'b1;
         @(negedge clk);
         if (valid && ready && !branch) begin
            exp           = ref_instr(ref_pc);
            exp_addr.word = ref_pc;
            check_instr(rdata, exp);
            check_addr(addr_out, exp_addr);
            ref_pc = ref_pc + ((exp[1:0] == 2'b11) ? 32'd4 : 32'd2);
            got++;
            xfers++;
         end
      end
   endtask

   task automatic report_test(input string name, input int err_before);
      if (errors == err_before) $display("test %s: ok", name);
      else $display("test %s: %0d mismatches", name, errors - err_before);
   endtask

   // --------------------------------------------------
   // Test sequence
   initial begin
      int e0;
      int a_fail;
      void'($urandom(32'h3a71ff88));
      rst_n        = 1'b0;
      branch       = 1'b0;
      fence        = 1'b0;
      ready        = 1'b0;
      addr_in.word = '0;
      iport_rsp    = '0;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;

      e0 = errors;
      do_branch(32'h0000_1000, 1'b0);
      run_stream(N_STREAM, 1'b0);
      report_test("straight-line stream", e0);

      e0 = errors;
      do_branch(32'h0000_2006, 1'b1);          // Odd generation with many cross-line instructions
      run_stream(N_STREAM, 1'b0);
      report_test("mixed lengths across lines", e0);

      e0 = errors;
      do_branch(32'h0000_2006, 1'b0);          // Same sequence again
      run_stream(N_STREAM, 1'b1);
      report_test("back-pressure", e0);

      e0 = errors;
      for (int k = 0; k < N_BRANCHES; k++) begin
         do_branch($urandom & 32'hffff_fffe, 1'b0);
         run_stream(N_PER_BR, 1'b1);
      end
      report_test("random branches", e0);

      e0 = errors;
      do_branch(32'h0000_2006, 1'b1);          // Stale lines must not show
      run_stream(N_STREAM, 1'b1);
      report_test("fence", e0);

      a_fail = uut.u_props.fail_cnt;
      if (port_errors == 0 && a_fail == 0) $display("test port discipline: ok");
      else $display("test port discipline: %0d port errors, %0d assertion failures",
                    port_errors, a_fail);

      $display("transfers %0d, mismatches %0d, port errors %0d, assertion failures %0d",
               xfers, errors, port_errors, a_fail);
      if (errors == 0 && port_errors == 0 && a_fail == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // Watchdog allows 40 cycles per expected transfer
   initial begin
      #(TOTAL_XFERS * 40 * CYCLE_NS);
      $display("Watchdog expired before all tests finished");
      $display("Simulation failed");
      $finish;
   end

endmodule

/* build.f */
+incdir+src
src/fetch_addr_pkg.sv
src/fetch_bus_pkg.sv
src/line_cache.sv
src/iport_arbiter.sv
src/line_prefetcher.sv
src/instr_aligner.sv
src/instr_prefetch_top.sv
tests/prefetch_properties.sv
tests/prefetch_tb.sv

/* Bender.yml */
package:
  name: instr_prefetch

sources:
  - include_dirs:
      - src
    files:
      - src/fetch_addr_pkg.sv
      - src/fetch_bus_pkg.sv
      - src/line_cache.sv
      - src/iport_arbiter.sv
      - src/line_prefetcher.sv
      - src/instr_aligner.sv
      - src/instr_prefetch_top.sv
  - target: test
    files:
      - tests/prefetch_properties.sv
      - tests/prefetch_tb.sv
